//--- common/aes_pkg.sv
`default_nettype none

package aes_pkg;

    localparam int AXIL_ADDR_W  = 6;
    localparam int AES_ROUNDS   = 10;
    localparam int PIPE_LATENCY = 11;

    typedef logic [127:0]           aes_block_t;  // bit 127 is byte 0 of the FIPS-197 order.
    typedef logic [7:0]             aes_byte_t;
    typedef logic [31:0]            axil_data_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUNNING,
        ST_DONE
    } ctrl_state_t;

    localparam axil_addr_t REG_KEY0   = 6'h00;  // key bits 127 to 96.
    localparam axil_addr_t REG_KEY1   = 6'h04;
    localparam axil_addr_t REG_KEY2   = 6'h08;
    localparam axil_addr_t REG_KEY3   = 6'h0C;
    localparam axil_addr_t REG_PT0    = 6'h10;
    localparam axil_addr_t REG_PT1    = 6'h14;
    localparam axil_addr_t REG_PT2    = 6'h18;
    localparam axil_addr_t REG_PT3    = 6'h1C;
    localparam axil_addr_t REG_CTRL   = 6'h20;  // bit 0 starts an encryption.
    localparam axil_addr_t REG_STATUS = 6'h24;  // bit 0 busy, bit 1 done.
    localparam axil_addr_t REG_CT0    = 6'h30;
    localparam axil_addr_t REG_CT1    = 6'h34;
    localparam axil_addr_t REG_CT2    = 6'h38;
    localparam axil_addr_t REG_CT3    = 6'h3C;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // forward S-box, entry 0 in the top byte.
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic aes_byte_t sbox(input aes_byte_t b);
        return SBOX_TABLE[2047 - 8*b -: 8];
    endfunction

    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // reduce by x^8+x^4+x^3+x+1.
    endfunction

    function automatic aes_byte_t mul3(input aes_byte_t b);
        return xtime(b) ^ b;
    endfunction

    function automatic aes_byte_t rcon_of(input int round_num);
        aes_byte_t rc;
        rc = 8'h01;
        for (int r = 1; r < round_num; r++)
            rc = xtime(rc);  // x^(round-1) in GF(2^8).
        return rc;
    endfunction

endpackage

`default_nettype wire

//--- aes/aes_key_step.sv
`timescale 1ns/100ps
`default_nettype none

module aes_key_step #(
    parameter logic [7:0] rcon = 8'h01
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire aes_pkg::aes_block_t prev_key,
    output aes_pkg::aes_block_t      next_key
);
    import aes_pkg::*;

    logic [31:0] w [4];
    logic [31:0] n [4];
    logic [31:0] sub_rot;

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            w[i] = prev_key[127 - 32*i -: 32];

        // RotWord then SubWord on the last word.
        sub_rot = {sbox(w[3][23:16]), sbox(w[3][15:8]), sbox(w[3][7:0]), sbox(w[3][31:24])};

        n[0] = w[0] ^ sub_rot ^ {rcon, 24'h000000};
        n[1] = w[1] ^ n[0];
        n[2] = w[2] ^ n[1];
        n[3] = w[3] ^ n[2];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            next_key <= '0;
        else
            next_key <= {n[0], n[1], n[2], n[3]};
    end

endmodule

`default_nettype wire

//--- aes/aes_round.sv
`timescale 1ns/100ps
`default_nettype none

module aes_round #(
    parameter bit is_final = 1'b0
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire aes_pkg::aes_block_t in_state,
    input  wire aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t      out_state
);
    import aes_pkg::*;

    aes_byte_t  sb  [16];
    aes_byte_t  sr  [16];
    aes_byte_t  mc  [16];
    aes_byte_t  col [4];
    aes_block_t mixed;

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            sb[i] = sbox(in_state[127 - 8*i -: 8]);

        // row r of column c comes from column c + r.
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                sr[4*c + r] = sb[4*((c + r) % 4) + r];

        for (int c = 0; c < 4; c++)
        begin
            for (int k = 0; k < 4; k++)
                col[k] = sr[4*c + k];
            mc[4*c + 0] = xtime(col[0]) ^ mul3(col[1]) ^ col[2] ^ col[3];
            mc[4*c + 1] = col[0] ^ xtime(col[1]) ^ mul3(col[2]) ^ col[3];
            mc[4*c + 2] = col[0] ^ col[1] ^ xtime(col[2]) ^ mul3(col[3]);
            mc[4*c + 3] = mul3(col[0]) ^ col[1] ^ col[2] ^ xtime(col[3]);
        end

        for (int i = 0; i < 16; i++)
            mixed[127 - 8*i -: 8] = is_final ? sr[i] : mc[i];  // last round has no MixColumns.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            out_state <= '0;
        else
            out_state <= mixed ^ round_key;
    end

endmodule

`default_nettype wire

//--- aes/aes_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module aes_pipeline (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_valid,
    input  wire aes_pkg::aes_block_t in_block,
    input  wire aes_pkg::aes_block_t in_key,
    output logic                out_valid,
    output aes_pkg::aes_block_t      out_block
);
    import aes_pkg::*;

    logic [PIPE_LATENCY-1:0] valid_q;
    aes_block_t              state0_q;
    aes_block_t              state_q   [0:AES_ROUNDS];
    aes_block_t              key_chain [0:AES_ROUNDS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q  <= '0;
            state0_q <= '0;
        end
        else
        begin
            valid_q  <= {valid_q[PIPE_LATENCY-2:0], in_valid};
            state0_q <= in_block ^ in_key;  // initial AddRoundKey.
        end
    end

    assign state_q[0]   = state0_q;
    assign key_chain[0] = in_key;

    // the key steps run one stage ahead, so key i lands together with the state of stage i-1.
    for (genvar i = 1; i <= AES_ROUNDS; i++)
    begin : g_stage
        aes_key_step #(
            .rcon     (rcon_of(i))
        ) u_key_step (
            .clk      (clk),
            .rst      (rst),
            .prev_key (key_chain[i-1]),
            .next_key (key_chain[i])
        );

        aes_round #(
            .is_final  (i == AES_ROUNDS)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .in_state  (state_q[i-1]),
            .round_key (key_chain[i]),
            .out_state (state_q[i])
        );
    end

    assign out_valid = valid_q[PIPE_LATENCY-1];
    assign out_block = state_q[AES_ROUNDS];

endmodule

`default_nettype wire

//--- logic/aes_axil_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module aes_axil_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire aes_pkg::axil_addr_t awaddr,
    input  wire                      wvalid,
    output logic                     wready,
    input  wire aes_pkg::axil_data_t wdata,
    input  wire [3:0]                wstrb,  // full-word writes only.
    output logic                     bvalid,
    input  wire                      bready,
    output logic [1:0]               bresp,
    input  wire                      arvalid,
    output logic                     arready,
    input  wire aes_pkg::axil_addr_t araddr,
    output logic                     rvalid,
    input  wire                      rready,
    output aes_pkg::axil_data_t      rdata,
    output logic [1:0]               rresp,
    output logic                     pipe_valid,
    output aes_pkg::aes_block_t      pipe_block,
    output aes_pkg::aes_block_t      pipe_key,
    input  wire                      result_valid,
    input  wire aes_pkg::aes_block_t result_block
);
    import aes_pkg::*;

    ctrl_state_t state;
    aes_block_t  key_q;
    aes_block_t  pt_q;
    aes_block_t  ct_q;
    logic        wr_fire;
    logic        rd_fire;
    logic        start_req;
    logic [1:0]  wr_resp;
    axil_data_t  rd_data;
    logic [1:0]  rd_resp;

    assign wr_fire    = awvalid && wvalid && !bvalid;  // address and data taken together.
    assign awready    = wr_fire;
    assign wready     = wr_fire;
    assign rd_fire    = arvalid && !rvalid;
    assign arready    = rd_fire;
    assign pipe_block = pt_q;
    assign pipe_key   = key_q;

    always_comb
    begin
        start_req = 1'b0;
        wr_resp   = RESP_OKAY;
        case (awaddr)
            REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3,
            REG_PT0, REG_PT1, REG_PT2, REG_PT3:
                wr_resp = RESP_OKAY;
            REG_CTRL:
            begin
                if (wdata[0] && state == ST_RUNNING)
                    wr_resp = RESP_SLVERR;  // one block in flight at a time.
                else
                    start_req = wdata[0];
            end
            default:
                wr_resp = RESP_SLVERR;  // status, ciphertext and holes.
        endcase
    end

    always_comb
    begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_KEY0:   rd_data = key_q[127:96];
            REG_KEY1:   rd_data = key_q[95:64];
            REG_KEY2:   rd_data = key_q[63:32];
            REG_KEY3:   rd_data = key_q[31:0];
            REG_PT0:    rd_data = pt_q[127:96];
            REG_PT1:    rd_data = pt_q[95:64];
            REG_PT2:    rd_data = pt_q[63:32];
            REG_PT3:    rd_data = pt_q[31:0];
            REG_CTRL:   rd_data = '0;
            REG_STATUS: rd_data = {30'd0, (state == ST_DONE), (state == ST_RUNNING)};
            REG_CT0:    rd_data = ct_q[127:96];
            REG_CT1:    rd_data = ct_q[95:64];
            REG_CT2:    rd_data = ct_q[63:32];
            REG_CT3:    rd_data = ct_q[31:0];
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            bresp <= wr_resp;
            case (awaddr)
                REG_KEY0: key_q[127:96] <= wdata;
                REG_KEY1: key_q[95:64]  <= wdata;
                REG_KEY2: key_q[63:32]  <= wdata;
                REG_KEY3: key_q[31:0]   <= wdata;
                REG_PT0:  pt_q[127:96]  <= wdata;
                REG_PT1:  pt_q[95:64]   <= wdata;
                REG_PT2:  pt_q[63:32]   <= wdata;
                REG_PT3:  pt_q[31:0]    <= wdata;
                default: ;
            endcase
        end
        if (rd_fire)
        begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
        if (result_valid)
            ct_q <= result_block;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ST_IDLE;
            pipe_valid <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
        end
        else
        begin
            pipe_valid <= wr_fire && start_req;  // one-cycle launch pulse.
            if (wr_fire && start_req)
                state <= ST_RUNNING;
            else if (result_valid && state == ST_RUNNING)
                state <= ST_DONE;

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_axil_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_axil_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      awvalid,
    output wire                      awready,
    input  wire aes_pkg::axil_addr_t awaddr,
    input  wire                      wvalid,
    output wire                      wready,
    input  wire aes_pkg::axil_data_t wdata,
    input  wire [3:0]                wstrb,
    output wire                      bvalid,
    input  wire                      bready,
    output wire [1:0]                bresp,
    input  wire                      arvalid,
    output wire                      arready,
    input  wire aes_pkg::axil_addr_t araddr,
    output wire                      rvalid,
    input  wire                      rready,
    output wire aes_pkg::axil_data_t rdata,
    output wire [1:0]                rresp
);
    import aes_pkg::*;

    logic       pipe_valid;
    aes_block_t pipe_block;
    aes_block_t pipe_key;
    logic       result_valid;
    aes_block_t result_block;

    aes_axil_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .pipe_valid   (pipe_valid),
        .pipe_block   (pipe_block),
        .pipe_key     (pipe_key),
        .result_valid (result_valid),
        .result_block (result_block)
    );

    aes_pipeline u_pipeline (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pipe_valid),
        .in_block  (pipe_block),
        .in_key    (pipe_key),
        .out_valid (result_valid),
        .out_block (result_block)
    );

endmodule

`default_nettype wire

//--- bench/aes_ref_model.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// product in GF(2^8) modulo x^8+x^4+x^3+x+1.
function automatic aes_byte_t gf_mult(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t p;
    aes_byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// a^254 is the inverse, and zero maps to zero.
function automatic aes_byte_t gf_inverse(input aes_byte_t a);
    aes_byte_t r;
    aes_byte_t p;
    r = 8'h01;
    p = a;
    for (int i = 0; i < 8; i++)
    begin
        if (i != 0)
            r = gf_mult(r, p);
        p = gf_mult(p, p);
    end
    return r;
endfunction

// S-box from the inverse and the affine map.
function automatic aes_byte_t sub_byte(input aes_byte_t b);
    aes_byte_t v;
    v = gf_inverse(b);
    return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]} ^ 8'h63;
endfunction

function automatic aes_block_t next_round_key(input aes_block_t k, input aes_byte_t rc);
    logic [31:0] w [4];
    logic [31:0] temp;
    for (int i = 0; i < 4; i++)
        w[i] = k[127 - 32*i -: 32];
    temp = {w[3][23:0], w[3][31:24]};  // RotWord.
    temp = {sub_byte(temp[31:24]), sub_byte(temp[23:16]),
            sub_byte(temp[15:8]), sub_byte(temp[7:0])};
    w[0] = w[0] ^ temp ^ {rc, 24'h000000};
    w[1] = w[1] ^ w[0];
    w[2] = w[2] ^ w[1];
    w[3] = w[3] ^ w[2];
    return {w[0], w[1], w[2], w[3]};
endfunction

function automatic aes_block_t encrypt_block(input aes_block_t key, input aes_block_t pt);
    aes_byte_t  s [16];
    aes_byte_t  t [16];
    aes_block_t blk;
    aes_block_t rk;
    aes_byte_t  rc;
    blk = pt ^ key;
    rk  = key;
    rc  = 8'h01;
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
        rk = next_round_key(rk, rc);
        rc = gf_mult(rc, 8'h02);
        for (int i = 0; i < 16; i++)
            s[i] = sub_byte(blk[127 - 8*i -: 8]);
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                t[4*c + r] = s[4*((c + r) % 4) + r];  // row r shifts left by r.
        for (int c = 0; c < 4; c++)
        begin
            s[4*c + 0] = gf_mult(t[4*c], 2) ^ gf_mult(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
            s[4*c + 1] = t[4*c] ^ gf_mult(t[4*c+1], 2) ^ gf_mult(t[4*c+2], 3) ^ t[4*c+3];
            s[4*c + 2] = t[4*c] ^ t[4*c+1] ^ gf_mult(t[4*c+2], 2) ^ gf_mult(t[4*c+3], 3);
            s[4*c + 3] = gf_mult(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mult(t[4*c+3], 2);
        end
        for (int i = 0; i < 16; i++)
            blk[127 - 8*i -: 8] = ((rnd == 10) ? t[i] : s[i]) ^ rk[127 - 8*i -: 8];
    end
    return blk;
endfunction

`endif

//--- bench/tb_aes_axil.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aes_axil;
    import aes_pkg::*;

    `include "aes_ref_model.svh"

    localparam int         NUM_RANDOM       = 30;
    localparam int         CYCLES_PER_BLOCK = 200;
    localparam int         TIMEOUT_CYCLES   = (NUM_RANDOM + 10) * CYCLES_PER_BLOCK * 5 / 2;
    localparam int         MAX_POLLS        = 50;
    localparam aes_block_t KAT_KEY          = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t KAT_PT           = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t KAT_CT           = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic        clk;
    logic        rst;
    logic        awvalid;
    logic        awready;
    axil_addr_t  awaddr;
    logic        wvalid;
    logic        wready;
    axil_data_t  wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    axil_addr_t  araddr;
    logic        rvalid;
    logic        rready;
    axil_data_t  rdata;
    logic [1:0]  rresp;
    logic [31:0] lcg_state = 32'd46;
    logic        fast_ready = 1'b0;  // zero ready delays when set.
    int          cycle_count = 0;

    aes_axil_top DUT (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("timeout: run not finished after %0d cycles",
                                        TIMEOUT_CYCLES));
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int ready_delay();
        return fast_ready ? 0 : int'(lcg_next() >> 30);  // 0 to 3 cycles.
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output logic [1:0] resp);
        int delay;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(posedge clk);  // address and data taken here.
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        delay = ready_delay();
        repeat (delay)
            @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        int delay;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        delay = ready_delay();
        repeat (delay)
            @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // writes key and plaintext, then reads both back.
    task automatic load_inputs(input aes_block_t key, input aes_block_t pt);
        logic [1:0] resp;
        axil_data_t word;
        for (int i = 0; i < 4; i++)
        begin
            axil_write(axil_addr_t'(REG_KEY0 + 4*i), key[127 - 32*i -: 32], resp);
            check_resp("BRESP", resp, RESP_OKAY);
            axil_write(axil_addr_t'(REG_PT0 + 4*i), pt[127 - 32*i -: 32], resp);
            check_resp("BRESP", resp, RESP_OKAY);
        end
        for (int i = 0; i < 4; i++)
        begin
            axil_read(axil_addr_t'(REG_KEY0 + 4*i), word, resp);
            check_resp("RRESP", resp, RESP_OKAY);
            check_data($sformatf("KEY%0d", i), word, key[127 - 32*i -: 32]);
            axil_read(axil_addr_t'(REG_PT0 + 4*i), word, resp);
            check_resp("RRESP", resp, RESP_OKAY);
            check_data($sformatf("PT%0d", i), word, pt[127 - 32*i -: 32]);
        end
    endtask

    task automatic wait_done();
        axil_data_t status;
        logic [1:0] resp;
        int         polls;
        polls  = 0;
        status = '0;
        while (!status[1])
        begin
            if (polls == MAX_POLLS)
                stop_with_failure("status never showed done within 50 reads");
            axil_read(REG_STATUS, status, resp);
            check_resp("RRESP", resp, RESP_OKAY);
            polls++;
        end
    endtask

    task automatic read_result(output aes_block_t ct);
        logic [1:0] resp;
        axil_data_t word;
        for (int i = 0; i < 4; i++)
        begin
            axil_read(axil_addr_t'(REG_CT0 + 4*i), word, resp);
            check_resp("RRESP", resp, RESP_OKAY);
            ct[127 - 32*i -: 32] = word;
        end
    endtask

    task automatic run_encryption(input aes_block_t key, input aes_block_t pt,
                                  output aes_block_t ct);
        logic [1:0] resp;
        load_inputs(key, pt);
        axil_write(REG_CTRL, 32'h1, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        wait_done();
        read_result(ct);
    endtask

    initial
    begin
        aes_block_t key;
        aes_block_t pt;
        aes_block_t ct;
        axil_data_t word;
        logic [1:0] resp;
        clk     = 1'b0;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (3)
            @(posedge clk);
        rst <= 1'b0;

        // model first, against FIPS-197 C.1.
        check_block("MODEL_CT", encrypt_block(KAT_KEY, KAT_PT), KAT_CT);
        run_encryption(KAT_KEY, KAT_PT, ct);
        check_block("CT", ct, KAT_CT);
        axil_read(REG_STATUS, word, resp);
        check_resp("RRESP", resp, RESP_OKAY);
        check_data("STATUS", word, 32'h2);

        axil_read(6'h28, word, resp);  // hole in the map.
        check_resp("RRESP", resp, RESP_SLVERR);
        check_data("RDATA", word, 32'h0);
        axil_write(REG_STATUS, 32'hffffffff, resp);
        check_resp("BRESP", resp, RESP_SLVERR);
        axil_read(REG_STATUS, word, resp);
        check_resp("RRESP", resp, RESP_OKAY);
        check_data("STATUS", word, 32'h2);
        axil_write(REG_CT0, 32'h12345678, resp);
        check_resp("BRESP", resp, RESP_SLVERR);
        axil_read(REG_CT0, word, resp);
        check_resp("RRESP", resp, RESP_OKAY);
        check_data("CT0", word, KAT_CT[127:96]);

        // second start while the first block is still in the pipeline.
        key = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        pt  = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        load_inputs(key, pt);
        fast_ready = 1'b1;
        axil_write(REG_CTRL, 32'h1, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        // a launch from the rejected start would pick up this plaintext.
        axil_write(REG_PT3, ~pt[31:0], resp);
        check_resp("BRESP", resp, RESP_OKAY);
        axil_write(REG_CTRL, 32'h1, resp);
        check_resp("BRESP", resp, RESP_SLVERR);
        axil_read(REG_STATUS, word, resp);
        check_resp("RRESP", resp, RESP_OKAY);
        check_data("STATUS", word, 32'h1);
        fast_ready = 1'b0;
        wait_done();
        read_result(ct);
        check_block("CT", ct, encrypt_block(key, pt));

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            key = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            pt  = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            run_encryption(key, pt, ct);
            check_block("CT", ct, encrypt_block(key, pt));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
common/aes_pkg.sv
aes/aes_key_step.sv
aes/aes_round.sv
aes/aes_pipeline.sv
logic/aes_axil_ctrl.sv
logic/aes_axil_top.sv
bench/tb_aes_axil.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -Mdir "$BUILD_DIR" --top-module tb_aes_axil -f sources.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
